//--- fm_mix.f
rtl/fm_sample_pkg.sv
rtl/fm_slot_pkg.sv
rtl/fm_slot_seq.sv
rtl/fm_chan_acc.sv
rtl/fm_dac_float.sv
rtl/fm_mix_top.sv
test/fm_mix_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the fm_mix testbench with Verilator.
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
rm -f sim.log

verilator --binary --timing --assert -Wno-fatal \
	--top-module fm_mix_tb \
	-f fm_mix.f \
	-o fm_mix_sim

./obj_dir/fm_mix_sim 2>&1 | tee sim.log

if grep -q '^\*\*\* PASSED \*\*\*$' sim.log; then
	echo "simulation passed"
	exit 0
else
	echo "simulation failed, see sim.log"
	exit 1
fi

//--- test/fm_mix_tb.sv
`default_nettype none

module fm_mix_tb;

	localparam int SLOTS = fm_slot_pkg::DEF_SLOTS;

	// frames per test
	localparam int N_RESET = 2;
	localparam int N_PAN = 6;
	localparam int N_NOISE = 4;
	localparam int N_SAT = 4;
	localparam int N_BOUND = 16;
	localparam int N_FLOAT = N_BOUND + 8;
	localparam int N_CAD = 40;
	localparam int N_TESTS = 6;

	// all test frames and the trailing flush frame
	localparam int TOTAL_FRAMES = N_RESET + N_PAN + N_NOISE + N_SAT + N_FLOAT + N_CAD + 1;

	// twice the nominal run time plus reset and pipeline slack
	localparam int TIMEOUT = TOTAL_FRAMES * SLOTS * 10 * 2 + 1000;

	// operator full scale
	localparam int OP_MAX = 2 ** (fm_sample_pkg::OP_W - 1) - 1;
	localparam int OP_MIN = -(2 ** (fm_sample_pkg::OP_W - 1));

	logic                                          clk;
	logic                                          rst;
	logic signed [fm_sample_pkg::OP_W-1:0]         op_out;
	logic        [1:0]                             rl;
	logic                                          ne;
	logic signed [fm_sample_pkg::NOISE_W-1:0]      noise;
	logic signed [fm_sample_pkg::OUT_W-1:0]        left;
	logic signed [fm_sample_pkg::OUT_W-1:0]        right;
	logic signed [fm_sample_pkg::OUT_W-1:0]        xleft;
	logic signed [fm_sample_pkg::OUT_W-1:0]        xright;
	logic                                          sample_valid;

	// inputs of the frame being played with one entry per slot
	int         f_op [SLOTS];
	logic [1:0] f_rl [SLOTS];
	logic       f_ne [SLOTS];
	int         f_noise [SLOTS];

	// expected results with one entry per frame
	int q_xl [$];
	int q_xr [$];
	int q_l [$];
	int q_r [$];
	int q_test [$];
	bit q_last [$];

	int n_pass = 0;
	int n_fail = 0;
	int t_checks [N_TESTS] = '{default: 0};
	int t_fails [N_TESTS] = '{default: 0};

	logic [31:0] lfsr = 32'h2f47575a;

	fm_mix_top #(
		.SLOTS (SLOTS)
	) UUT (
		.clk          (clk),
		.rst          (rst),
		.op_out       (op_out),
		.rl           (rl),
		.ne           (ne),
		.noise        (noise),
		.left         (left),
		.right        (right),
		.xleft        (xleft),
		.xright       (xright),
		.sample_valid (sample_valid)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	function automatic string test_name(input int tid);
		case (tid)
			0: return "reset";
			1: return "panning";
			2: return "noise";
			3: return "saturation";
			4: return "float";
			default: return "cadence";
		endcase
	endfunction

	// fibonacci lfsr with taps 32 22 2 1 stepped once per bit taken
	function automatic logic [31:0] next_bits(input int n);
		logic [31:0] r;
		r = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
			r = {r[30:0], lfsr[0]};
		end
		return r;
	endfunction

	// n random bits read as a two's complement value
	function automatic int rand_signed(input int n);
		logic [31:0] b;
		int v;
		b = next_bits(n);
		v = int'(b);
		if (b[n-1]) begin
			v = v - (1 << n);
		end
		return v;
	endfunction

	// reference frame sum for one side (0 left and 1 right)
	function automatic int frame_sum(input int side);
		int acc;
		int v;
		acc = 0;
		for (int s = 0; s < SLOTS; s++) begin
			// noise x16 takes over the last slot when enabled
			if (s == SLOTS - 1 && f_ne[s]) begin
				v = f_noise[s] * 16;
			end else begin
				v = f_op[s];
			end
			if (f_rl[s][side]) begin
				acc += v;
			end
		end
		if (acc > 32767) begin
			acc = 32767;
		end else if (acc < -32768) begin
			acc = -32768;
		end
		return acc;
	endfunction

	// reference float rule picks the smallest shift giving a 10 bit mantissa
	function automatic int float_rebuild(input int x);
		int e;
		int m;
		e = 0;
		m = x;
		while ((m > 511 || m < -512) && e < 6) begin
			e++;
			m = x >>> e;
		end
		return m * (1 << e);
	endfunction

	// sums around the mantissa and sample edges
	function automatic int bound_target(input int k);
		case (k)
			0: return 0;
			1: return 1;
			2: return -1;
			3: return 511;
			4: return -512;
			5: return 512;
			6: return -513;
			7: return 1023;
			8: return 1024;
			9: return 2048;
			10: return -4096;
			11: return 8191;
			12: return 16384;
			13: return -16385;
			14: return 32767;
			default: return -32768;
		endcase
	endfunction

	task automatic check_value(input int tid, input string what, input int expv, input int actv);
		t_checks[tid]++;
		assert (expv == actv) begin
			n_pass++;
		end else begin
			n_fail++;
			t_fails[tid]++;
			$display("Fail %s %s: expected %0d, actual %0d", test_name(tid), what, expv, actv);
		end
	endtask

	task automatic check_cond(input int tid, input bit ok, input string msg);
		t_checks[tid]++;
		assert (ok) begin
			n_pass++;
		end else begin
			n_fail++;
			t_fails[tid]++;
			$display("Error in test %s: %s", test_name(tid), msg);
		end
	endtask

	task automatic fill_random();
		for (int s = 0; s < SLOTS; s++) begin
			f_op[s] = rand_signed(fm_sample_pkg::OP_W);
			f_rl[s] = 2'(next_bits(2));
			f_ne[s] = 1'(next_bits(1));
			f_noise[s] = rand_signed(fm_sample_pkg::NOISE_W);
		end
	endtask

	// spread a target sum over the first slots with both sides panned
	task automatic fill_sum(input int target);
		int rem;
		int chunk;
		rem = target;
		for (int s = 0; s < SLOTS; s++) begin
			chunk = (rem > OP_MAX) ? OP_MAX : ((rem < OP_MIN) ? OP_MIN : rem);
			f_op[s] = chunk;
			rem -= chunk;
			f_rl[s] = 2'b11;
			f_ne[s] = 1'b0;
			f_noise[s] = 0;
		end
	endtask

	task automatic push_expected(input int tid, input bit last);
		int xl;
		int xr;
		xl = frame_sum(0);
		xr = frame_sum(1);
		q_xl.push_back(xl);
		q_xr.push_back(xr);
		q_l.push_back(float_rebuild(xl));
		q_r.push_back(float_rebuild(xr));
		q_test.push_back(tid);
		q_last.push_back(last);
	endtask

	// one slot per clock with inputs changing just after the edge
	task automatic drive_slots();
		for (int s = 0; s < SLOTS; s++) begin
			op_out <= fm_sample_pkg::OP_W'(f_op[s]);
			rl     <= f_rl[s];
			ne     <= f_ne[s];
			noise  <= fm_sample_pkg::NOISE_W'(f_noise[s]);
			@(posedge clk);
		end
	endtask

	task automatic play_frame(input int tid, input bit last);
		push_expected(tid, last);
		drive_slots();
	endtask

	initial begin : watchdog
		#(TIMEOUT);
		$display("run timed out with %0d frames still unchecked", q_xl.size());
		$display("*** FAILED ***");
		$finish;
	end

	// outputs are read on the falling edge away from the register updates
	initial begin : compare
		int cycle;
		int last_cycle;
		bit seen;
		int tid;
		cycle = 0;
		last_cycle = 0;
		seen = 1'b0;
		forever begin
			@(negedge clk);
			if (rst) begin
				check_cond(0, sample_valid === 1'b0, "sample_valid high while rst is asserted");
			end else begin
				cycle++;
				if (sample_valid === 1'b1) begin
					if (q_xl.size() == 0) begin
						check_cond(N_TESTS - 1, 1'b0, "sample_valid pulsed with no frame pending");
					end else begin
						tid = q_test.pop_front();
						// first frame comes 2 cycles after slot 0 of the second frame
						if (!seen) begin
							check_value(tid, "first valid cycle", SLOTS + 4, cycle);
						end else begin
							check_value(tid, "valid spacing", SLOTS, cycle - last_cycle);
						end
						seen = 1'b1;
						last_cycle = cycle;
						check_value(tid, "xleft", q_xl.pop_front(), int'(xleft));
						check_value(tid, "xright", q_xr.pop_front(), int'(xright));
						check_value(tid, "left", q_l.pop_front(), int'(left));
						check_value(tid, "right", q_r.pop_front(), int'(right));
						if (q_last.pop_front()) begin
							$display("test %s done: %0d checks, %0d failed",
								test_name(tid), t_checks[tid], t_fails[tid]);
						end
					end
				end
			end
		end
	end

	initial begin : stimulus
		rst = 1'b1;
		op_out = '0;
		rl = '0;
		ne = 1'b0;
		noise = '0;
		repeat (2) @(posedge clk);
		rst <= 1'b0;

		// random frames straight out of reset
		for (int k = 0; k < N_RESET; k++) begin
			fill_random();
			play_frame(0, k == N_RESET - 1);
		end

		// fixed pan patterns none, left, right, both, then mixed per slot
		for (int k = 0; k < N_PAN; k++) begin
			fill_random();
			for (int s = 0; s < SLOTS; s++) begin
				f_ne[s] = 1'b0;
				if (k < 4) begin
					f_rl[s] = 2'(k);
				end
			end
			play_frame(1, k == N_PAN - 1);
		end

		// noise at both extremes, noise disabled, random noise
		for (int k = 0; k < N_NOISE; k++) begin
			fill_random();
			for (int s = 0; s < SLOTS; s++) begin
				case (k)
					0: begin
						f_ne[s] = 1'b1;
						f_noise[s] = 511;
						f_rl[s] = 2'b11;
					end
					1: begin
						f_ne[s] = 1'b1;
						f_noise[s] = -512;
						f_rl[s] = 2'b11;
					end
					2: f_ne[s] = 1'b0;
					default: f_ne[s] = 1'b1;
				endcase
			end
			play_frame(2, k == N_NOISE - 1);
		end

		// full scale positive then negative on both sides
		for (int k = 0; k < N_SAT; k++) begin
			for (int s = 0; s < SLOTS; s++) begin
				f_op[s] = (k < 2) ? OP_MAX : OP_MIN;
				f_rl[s] = 2'b11;
				f_ne[s] = 1'b0;
				f_noise[s] = 0;
			end
			play_frame(3, k == N_SAT - 1);
		end

		// boundary sums then random sums reaching past the limits
		for (int k = 0; k < N_FLOAT; k++) begin
			fill_sum((k < N_BOUND) ? bound_target(k) : rand_signed(17));
			play_frame(4, k == N_FLOAT - 1);
		end

		// long random run
		for (int k = 0; k < N_CAD; k++) begin
			fill_random();
			play_frame(5, k == N_CAD - 1);
		end

		// flush frame closes the last test frame and its own sum is not checked
		fill_sum(0);
		drive_slots();

		while (q_xl.size() != 0) begin
			@(negedge clk);
		end

		$display("checks passed %0d, failed %0d", n_pass, n_fail);
		if (n_fail == 0) begin
			$display("*** PASSED ***");
		end else begin
			$display("*** FAILED ***");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- rtl/fm_mix_top.sv
`default_nettype none

module fm_mix_top #(
	parameter int SLOTS = fm_slot_pkg::DEF_SLOTS
) (
	input  logic                                   clk,
	input  logic                                   rst,
	input  logic signed [fm_sample_pkg::OP_W-1:0]    op_out,
	input  logic        [1:0]                      rl,
	input  logic                                   ne,
	input  logic signed [fm_sample_pkg::NOISE_W-1:0] noise,
	output logic signed [fm_sample_pkg::OUT_W-1:0]   left,
	output logic signed [fm_sample_pkg::OUT_W-1:0]   right,
	output logic signed [fm_sample_pkg::OUT_W-1:0]   xleft,
	output logic signed [fm_sample_pkg::OUT_W-1:0]   xright,
	output logic                                   sample_valid
);

	// registered slot stream
	logic signed [fm_sample_pkg::OP_W-1:0] op_val;
	logic                                en_left;
	logic                                en_right;
	logic                                zero;

	// per side frame samples
	logic signed [fm_sample_pkg::OUT_W-1:0] sample_left;
	logic signed [fm_sample_pkg::OUT_W-1:0] sample_right;
	logic                                 valid_left;
	logic                                 valid_right;

	fm_slot_seq #(
		.SLOTS (SLOTS)
	) u_seq (
		.clk      (clk),
		.rst      (rst),
		.op_out   (op_out),
		.rl       (rl),
		.ne       (ne),
		.noise    (noise),
		.op_val   (op_val),
		.en_left  (en_left),
		.en_right (en_right),
		.zero     (zero)
	);

	fm_chan_acc u_acc_left (
		.clk          (clk),
		.rst          (rst),
		.zero         (zero),
		.en           (en_left),
		.op_val       (op_val),
		.sample       (sample_left),
		.sample_valid (valid_left)
	);

	fm_chan_acc u_acc_right (
		.clk          (clk),
		.rst          (rst),
		.zero         (zero),
		.en           (en_right),
		.op_val       (op_val),
		.sample       (sample_right),
		.sample_valid (valid_right)
	);

	// both sides share the frame timing, left valid stands for both
	fm_dac_float u_dac_left (
		.clk       (clk),
		.rst       (rst),
		.sample    (sample_left),
		.in_valid  (valid_left),
		.lin       (left),
		.exact     (xleft),
		.out_valid (sample_valid)
	);

	fm_dac_float u_dac_right (
		.clk       (clk),
		.rst       (rst),
		.sample    (sample_right),
		.in_valid  (valid_right),
		.lin       (right),
		.exact     (xright),
		.out_valid ()
	);

endmodule

`default_nettype wire

//--- rtl/fm_dac_float.sv
`default_nettype none

module fm_dac_float (
	input  logic                                 clk,
	input  logic                                 rst,
	input  logic signed [fm_sample_pkg::OUT_W-1:0] sample,
	input  logic                                 in_valid,
	output logic signed [fm_sample_pkg::OUT_W-1:0] lin,
	output logic signed [fm_sample_pkg::OUT_W-1:0] exact,
	output logic                                 out_valid
);

	// a 16 bit sample shifted right by 6 always fits 10 bits
	localparam int MAX_EXP = fm_sample_pkg::OUT_W - fm_sample_pkg::MAN_W;

	// mantissa range
	localparam int MAN_MAX = 2 ** (fm_sample_pkg::MAN_W - 1) - 1;
	localparam int MAN_MIN = -(2 ** (fm_sample_pkg::MAN_W - 1));

	logic        [fm_sample_pkg::EXP_W-1:0] exp_sel;
	logic        [fm_sample_pkg::EXP_W-1:0] exp_q;
	logic signed [fm_sample_pkg::MAN_W-1:0] man;
	logic signed [fm_sample_pkg::OUT_W-1:0] lin_next;

	// true when a shifted value is a valid signed mantissa
	function automatic logic fits_man(input logic signed [fm_sample_pkg::OUT_W-1:0] v);
		fits_man = (v >= MAN_MIN) && (v <= MAN_MAX);
	endfunction

	// scan from the top down so the smallest fitting exponent wins
	always_comb begin
		exp_sel = fm_sample_pkg::EXP_W'(MAX_EXP);
		for (int e = MAX_EXP; e >= 0; e--) begin
			if (fits_man(sample >>> e)) begin
				exp_sel = fm_sample_pkg::EXP_W'(e);
			end
		end
	end

	// arithmetic shift drops the low bits and rounds toward -inf
	assign man = fm_sample_pkg::MAN_W'(sample >>> exp_sel);

	// what the serial DAC actually reproduces
	assign lin_next = fm_sample_pkg::OUT_W'(man) <<< exp_sel;

	always_ff @(posedge clk) begin
		if (rst) begin
			lin       <= '0;
			exact     <= '0;
			exp_q     <= '0;
			out_valid <= 1'b0;
		end else begin
			out_valid <= in_valid;
			// hold the last sample between frames
			if (in_valid) begin
				lin   <= lin_next;
				exact <= sample;
				exp_q <= exp_sel;
			end
		end
	end

	// quantization error is below one step of the chosen exponent
	a_quant_err: assert property (@(posedge clk) disable iff (rst)
		in_valid |=> (lin <= exact) && ((exact - lin) < (1 << exp_q)));

endmodule

`default_nettype wire

//--- rtl/fm_chan_acc.sv
`default_nettype none

module fm_chan_acc (
	input  logic                                 clk,
	input  logic                                 rst,
	input  logic                                 zero,
	input  logic                                 en,
	input  logic signed [fm_sample_pkg::OP_W-1:0]  op_val,
	output logic signed [fm_sample_pkg::OUT_W-1:0] sample,
	output logic                                 sample_valid
);

	logic signed [fm_sample_pkg::ACC_W-1:0] sum;
	logic signed [fm_sample_pkg::ACC_W-1:0] slot_term;
	logic signed [fm_sample_pkg::OUT_W-1:0] sum_sat;

	// the first frame start after reset closes an empty frame
	logic primed;

	// sign extended slot, or nothing when this side is not panned
	assign slot_term = en ? fm_sample_pkg::ACC_W'(op_val) : '0;

	// clamp the frame sum to the 16 bit sample range
	always_comb begin
		if (sum > fm_sample_pkg::OUT_MAX) begin
			sum_sat = fm_sample_pkg::OUT_W'(fm_sample_pkg::OUT_MAX);
		end else if (sum < fm_sample_pkg::OUT_MIN) begin
			sum_sat = fm_sample_pkg::OUT_W'(fm_sample_pkg::OUT_MIN);
		end else begin
			sum_sat = fm_sample_pkg::OUT_W'(sum);
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			sum          <= '0;
			sample       <= '0;
			sample_valid <= 1'b0;
			primed       <= 1'b0;
		end else begin
			sample_valid <= 1'b0;
			if (zero) begin
				// close the previous frame and restart with slot 0
				sample       <= sum_sat;
				sample_valid <= primed;
				primed       <= 1'b1;
				sum          <= slot_term;
			end else begin
				sum <= sum + slot_term;
			end
		end
	end

	// adding two values of the same sign must keep that sign,
	// otherwise the 19 bit sum has wrapped
	a_no_wrap: assert property (@(posedge clk) disable iff (rst)
		!zero |=> ($past(sum[fm_sample_pkg::ACC_W-1]) != $past(slot_term[fm_sample_pkg::ACC_W-1]))
			|| (sum[fm_sample_pkg::ACC_W-1] == $past(sum[fm_sample_pkg::ACC_W-1])));

endmodule

`default_nettype wire

//--- rtl/fm_slot_seq.sv
`default_nettype none

module fm_slot_seq #(
	parameter int SLOTS = fm_slot_pkg::DEF_SLOTS
) (
	input  logic                                   clk,
	input  logic                                   rst,
	input  logic signed [fm_sample_pkg::OP_W-1:0]    op_out,
	input  logic        [1:0]                      rl,
	input  logic                                   ne,
	input  logic signed [fm_sample_pkg::NOISE_W-1:0] noise,
	output logic signed [fm_sample_pkg::OP_W-1:0]    op_val,
	output logic                                   en_left,
	output logic                                   en_right,
	output logic                                   zero
);

	// index of the noise slot
	localparam logic [fm_slot_pkg::SLOT_W-1:0] LAST_SLOT = fm_slot_pkg::SLOT_W'(SLOTS - 1);

	logic [fm_slot_pkg::SLOT_W-1:0] cnt;
	logic                           last;
	logic signed [fm_sample_pkg::OP_W-1:0] noise_op;
	logic signed [fm_sample_pkg::OP_W-1:0] op_sel;

	assign last = (cnt == LAST_SLOT);

	// noise x16 with the low bits padded by zeros
	assign noise_op = {noise, {fm_sample_pkg::NOISE_SHIFT{1'b0}}};

	// noise only replaces the operator in the last slot
	assign op_sel = (last && ne) ? noise_op : op_out;

	// slot counter starts at 0 on the first cycle out of reset
	always_ff @(posedge clk) begin
		if (rst) begin
			cnt <= '0;
		end else if (last) begin
			cnt <= '0;
		end else begin
			cnt <= cnt + 1'b1;
		end
	end

	// pan bits and frame start flag of the registered slot
	always_ff @(posedge clk) begin
		if (rst) begin
			en_left  <= 1'b0;
			en_right <= 1'b0;
			zero     <= 1'b0;
		end else begin
			en_left  <= rl[0];
			en_right <= rl[1];
			zero     <= (cnt == '0);
		end
	end

	// slot payload aligned with the flags above
	always_ff @(posedge clk) begin
		op_val <= op_sel;
	end

	// frame start comes back after exactly SLOTS cycles and not before
	a_zero_period: assert property (@(posedge clk) disable iff (rst)
		zero |=> !zero [*SLOTS-1] ##1 zero);

endmodule

`default_nettype wire

//--- rtl/fm_slot_pkg.sv
`default_nettype none

package fm_slot_pkg;

	// one operator slot per clock, the frame wraps after the last slot
	// 32 slots matches 8 channels x 4 operators
	localparam int DEF_SLOTS = 32;

	// slot counter width, enough for the largest frame
	localparam int SLOT_W = 5;

	// smaller frames (4..32, power of two) reuse the same counter,
	// it simply wraps earlier

endpackage

`default_nettype wire

//--- rtl/fm_sample_pkg.sv
`default_nettype none

package fm_sample_pkg;

	// operator output as it leaves the phase/envelope engine
	localparam int OP_W = 14;

	// noise generator output, signed
	localparam int NOISE_W = 10;

	// noise sits in the upper bits of the operator word
	localparam int NOISE_SHIFT = OP_W - NOISE_W;

	// 32 full-scale slots need 14 + 5 bits
	localparam int ACC_W = 19;

	// sample width presented to the DAC stage
	localparam int OUT_W = 16;

	// clamp limits for the frame sum
	localparam int OUT_MAX = 32767;
	localparam int OUT_MIN = -32768;

	// float DAC format, 10 bit signed mantissa and 3 bit exponent
	localparam int MAN_W = 10;
	localparam int EXP_W = 3;

endpackage

`default_nettype wire
